//--- tb.f
logic/riscv_isa_pkg.sv
logic/wb_pkg.sv
logic/fetch_if.sv
logic/decoder.sv
logic/imm_gen.sv
logic/instr_fetch.sv
logic/decode_stage.sv
logic/frontend_top.sv
sim/frontend_assert.sv
sim/frontend_tb.sv

//--- Bender.yml
package:
  name: rv32_frontend

sources:
  - logic/riscv_isa_pkg.sv
  - logic/wb_pkg.sv
  - logic/fetch_if.sv
  - logic/decoder.sv
  - logic/imm_gen.sv
  - logic/instr_fetch.sv
  - logic/decode_stage.sv
  - logic/frontend_top.sv
  - target: simulation
    files:
      - sim/frontend_assert.sv
      - sim/frontend_tb.sv

//--- sim/frontend_tb.sv
`default_nettype none

module frontend_tb;

	import riscv_isa_pkg::*;
	import wb_pkg::*;

	logic         clk;
	logic         rst;
	logic         redirect;
	wb_addr_t     redirect_pc;
	logic         wb_cyc;
	logic         wb_stb;
	wb_addr_t     wb_adr;
	wb_data_t     wb_rdata;
	logic         wb_ack;
	logic         dec_valid;
	logic         dec_ready;
	decoded_instr dec_op;
	reg_idx_t     dec_rd;
	reg_idx_t     dec_rs1;
	reg_idx_t     dec_rs2;
	wb_data_t     dec_imm;
	wb_data_t     dec_pc;

	wb_data_t     mem [0:1023];
	integer       seed = 32'h24e5;
	int           waits;
	bit           in_cycle;
	int           ready_ctl; // 0 low, 1 high, 2 random.
	int           errors;
	int           test_errors;
	int           checks;
	int           tests_run;

	wb_data_t     prog_q[$];
	decoded_instr exp_op_q[$];
	wb_data_t     exp_imm_q[$];
	wb_addr_t     addr_q[$];
	decoded_instr got_op[$];
	wb_data_t     got_imm[$];
	wb_data_t     got_pc[$];
	wb_data_t     got_fields[$]; // {rs2, rs1, rd} packed low.

	frontend_top #(
		.riscv_m_core(1'b1)
	) dut_i (
		.clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_rdata(wb_rdata),
		.wb_ack(wb_ack), .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_op(dec_op),
		.dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm),
		.dec_pc(dec_pc)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory slave with 0 to 3 wait states.
	always @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			in_cycle = 1'b0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
			in_cycle = 1'b0;
			addr_q.push_back(wb_adr);
		end else if (wb_cyc && wb_stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				waits = $unsigned($random(seed)) % 4;
			end
			if (waits == 0) begin
				wb_ack <= 1'b1;
				wb_rdata <= mem[wb_adr[11:2]];
			end else begin
				waits--;
			end
		end
	end

	always @(posedge clk) begin
		if (ready_ctl == 2)
			dec_ready <= $random(seed) & 1;
		else
			dec_ready <= ready_ctl[0];
	end

	always @(posedge clk) begin
		if (!rst && dec_valid && dec_ready) begin
			got_op.push_back(dec_op);
			got_imm.push_back(dec_imm);
			got_pc.push_back(dec_pc);
			got_fields.push_back({17'd0, dec_rs2, dec_rs1, dec_rd});
		end
	end

	// addi x0, x0, index: the fill word names its own address.
	function automatic wb_data_t fill_word(int idx);
		return {idx[11:0], 5'd0, 3'd0, 5'd0, 7'b0010011};
	endfunction

	function automatic wb_data_t enc_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
		return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
	endfunction

	function automatic wb_data_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
		reg_idx_t rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic wb_data_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3, logic [6:0] opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic wb_data_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic wb_data_t enc_j(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic check_op(string name, decoded_instr exp, decoded_instr act);
		checks++;
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %s got %s", $time, name, exp.name(),
				act.name());
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_data(string name, wb_data_t exp, wb_data_t act);
		checks++;
		if (exp !== act) begin
			$display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic abort_run(string what);
		$display("timeout: %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic add_case(wb_data_t word, decoded_instr op, wb_data_t imm);
		prog_q.push_back(word);
		exp_op_q.push_back(op);
		exp_imm_q.push_back(imm);
	endtask

	// reset with the program at address 0 over the fill pattern.
	task automatic start_dut();
		@(posedge clk);
		rst <= 1'b1;
		redirect <= 1'b0;
		@(posedge clk);
		got_op.delete();
		got_imm.delete();
		got_pc.delete();
		got_fields.delete();
		addr_q.delete();
		for (int i = 0; i < 1024; i++)
			mem[i] = fill_word(i);
		foreach (prog_q[k])
			mem[k] = prog_q[k];
		test_errors = 0;
		repeat (7) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic wait_items(int n, string what);
		int cycles;
		cycles = 0;
		while (got_pc.size() < n) begin
			@(negedge clk);
			cycles++;
			if (cycles > 40 * n + 100)
				abort_run({what, " produced too few decoded words"});
		end
	endtask

	task automatic finish_test(string name);
		tests_run++;
		$display("%s: %s", name, (test_errors == 0) ? "ok" : "errors found");
		prog_q.delete();
		exp_op_q.delete();
		exp_imm_q.delete();
	endtask

	task automatic check_stream(int first, wb_addr_t pc0, string name);
		for (int k = 0; k < 12; k++) begin
			check_data({name, " dec_pc"}, pc0 + 4 * k, got_pc[first + k]);
			check_data({name, " dec_imm"}, (pc0 >> 2) + k, got_imm[first + k]);
			check_op({name, " dec_op"}, INSTR_ADDI, got_op[first + k]);
		end
	endtask

	task automatic test_sequential();
		start_dut();
		wait_items(12, "sequential");
		check_stream(0, 32'h0, "sequential");
		for (int k = 0; k < 12; k++)
			check_data("wb_adr", 4 * k, addr_q[k]);
		finish_test("sequential");
	endtask

	task automatic run_table(string name);
		int n;
		n = prog_q.size();
		start_dut();
		wait_items(n, name);
		foreach (exp_op_q[k]) begin
			check_op({name, " dec_op"}, exp_op_q[k], got_op[k]);
			check_data({name, " dec_pc"}, 4 * k, got_pc[k]);
		end
		finish_test(name);
	endtask

	task automatic test_base_decode();
		add_case(enc_r(7'h00, 3'd0, 7'b0110011), INSTR_ADD, 0);
		add_case(enc_r(7'h20, 3'd0, 7'b0110011), INSTR_SUB, 0);
		add_case(enc_r(7'h00, 3'd1, 7'b0110011), INSTR_SLL, 0);
		add_case(enc_r(7'h00, 3'd2, 7'b0110011), INSTR_SLT, 0);
		add_case(enc_r(7'h00, 3'd3, 7'b0110011), INSTR_SLTU, 0);
		add_case(enc_r(7'h00, 3'd4, 7'b0110011), INSTR_XOR, 0);
		add_case(enc_r(7'h00, 3'd5, 7'b0110011), INSTR_SRL, 0);
		add_case(enc_r(7'h20, 3'd5, 7'b0110011), INSTR_SRA, 0);
		add_case(enc_r(7'h00, 3'd6, 7'b0110011), INSTR_OR, 0);
		add_case(enc_r(7'h00, 3'd7, 7'b0110011), INSTR_AND, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b0010011), INSTR_ADDI, 0);
		add_case(enc_r(7'h00, 3'd1, 7'b0010011), INSTR_SLLI, 0);
		add_case(enc_r(7'h00, 3'd2, 7'b0010011), INSTR_SLTI, 0);
		add_case(enc_r(7'h00, 3'd3, 7'b0010011), INSTR_SLTIU, 0);
		add_case(enc_r(7'h00, 3'd4, 7'b0010011), INSTR_XORI, 0);
		add_case(enc_r(7'h00, 3'd5, 7'b0010011), INSTR_SRLI, 0);
		add_case(enc_r(7'h20, 3'd5, 7'b0010011), INSTR_SRAI, 0);
		add_case(enc_r(7'h00, 3'd6, 7'b0010011), INSTR_ORI, 0);
		add_case(enc_r(7'h00, 3'd7, 7'b0010011), INSTR_ANDI, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b0000011), INSTR_LB, 0);
		add_case(enc_r(7'h00, 3'd1, 7'b0000011), INSTR_LH, 0);
		add_case(enc_r(7'h00, 3'd2, 7'b0000011), INSTR_LW, 0);
		add_case(enc_r(7'h00, 3'd3, 7'b0000011), INSTR_LW, 0); // table default.
		add_case(enc_r(7'h00, 3'd4, 7'b0000011), INSTR_LBU, 0);
		add_case(enc_r(7'h00, 3'd5, 7'b0000011), INSTR_LHU, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b0100011), INSTR_SB, 0);
		add_case(enc_r(7'h00, 3'd1, 7'b0100011), INSTR_SH, 0);
		add_case(enc_r(7'h00, 3'd2, 7'b0100011), INSTR_SW, 0);
		add_case(enc_r(7'h00, 3'd3, 7'b0100011), INSTR_SW, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b1100011), INSTR_BEQ, 0);
		add_case(enc_r(7'h00, 3'd1, 7'b1100011), INSTR_BNE, 0);
		add_case(enc_r(7'h00, 3'd4, 7'b1100011), INSTR_BLT, 0);
		add_case(enc_r(7'h00, 3'd5, 7'b1100011), INSTR_BGE, 0);
		add_case(enc_r(7'h00, 3'd6, 7'b1100011), INSTR_BLTU, 0);
		add_case(enc_r(7'h00, 3'd7, 7'b1100011), INSTR_BGEU, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b1101111), INSTR_JAL, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b1100111), INSTR_JALR, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b0010111), INSTR_AUIPC, 0);
		add_case(enc_r(7'h00, 3'd0, 7'b0110111), INSTR_LUI, 0);
		run_table("base_decode");
	endtask

	task automatic test_m_ext();
		decoded_instr m_ops[8];
		m_ops = '{INSTR_MUL, INSTR_MULH, INSTR_MULHSU, INSTR_MULHU, INSTR_DIV, INSTR_DIVU,
			INSTR_REM, INSTR_REMU};
		for (int f = 0; f < 8; f++)
			add_case(enc_r(7'h01, f[2:0], 7'b0110011), m_ops[f], 0);
		add_case(32'h0000_007f, INSTR_ILLEGAL, 0);
		add_case(32'h0000_000b, INSTR_ILLEGAL, 0);
		run_table("m_extension");
	endtask

	task automatic test_imm_fields();
		add_case(enc_i(12'hffb, 5'd7, 3'd0, 5'd5, 7'b0010011), INSTR_ADDI, 32'hffff_fffb);
		add_case(enc_i(12'h7ff, 5'd31, 3'd2, 5'd30, 7'b0000011), INSTR_LW, 32'h0000_07ff);
		add_case(enc_s(12'hf9c, 5'd9, 5'd3, 3'd2, 7'b0100011), INSTR_SW, 32'hffff_ff9c);
		add_case(enc_b(13'h1ff8, 5'd4, 5'd6, 3'd0), INSTR_BEQ, 32'hffff_fff8);
		add_case(enc_b(13'h0ffe, 5'd17, 5'd18, 3'd1), INSTR_BNE, 32'h0000_0ffe);
		add_case({20'habcde, 5'd12, 7'b0110111}, INSTR_LUI, 32'habcd_e000);
		add_case(enc_j(21'h1ff65c, 5'd1), INSTR_JAL, 32'hffff_f65c);
		add_case(enc_j(21'h0ffffe, 5'd2), INSTR_JAL, 32'h000f_fffe);
		start_dut();
		wait_items(prog_q.size(), "immediates");
		foreach (prog_q[k]) begin
			check_op("dec_op", exp_op_q[k], got_op[k]);
			check_data("dec_imm", exp_imm_q[k], got_imm[k]);
			check_data("dec_rd", prog_q[k][11:7], got_fields[k][4:0]);
			check_data("dec_rs1", prog_q[k][19:15], got_fields[k][9:5]);
			check_data("dec_rs2", prog_q[k][24:20], got_fields[k][14:10]);
		end
		finish_test("immediates");
	endtask

	task automatic test_backpressure();
		@(negedge clk);
		ready_ctl = 2;
		start_dut();
		wait_items(24, "backpressure");
		check_stream(0, 32'h0, "backpressure");
		check_stream(12, 32'h30, "backpressure");
		@(negedge clk);
		ready_ctl = 1;
		finish_test("backpressure");
	endtask

	task automatic test_redirect();
		int cycles;
		int n0;
		start_dut();
		wait_items(2, "redirect");
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > 100)
				abort_run("no bus cycle seen before the redirect");
		end while (!(wb_cyc && !wb_ack));
		ready_ctl = 0;
		@(posedge clk);
		redirect <= 1'b1;
		redirect_pc <= 32'h200;
		@(posedge clk);
		redirect <= 1'b0;
		@(negedge clk);
		n0 = got_pc.size();
		ready_ctl = 1;
		wait_items(n0 + 12, "redirect");
		check_stream(n0, 32'h200, "redirect");
		finish_test("redirect");
	endtask

	initial begin
		rst = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		wb_ack = 1'b0;
		wb_rdata = '0;
		dec_ready = 1'b0;
		ready_ctl = 1;
		errors = 0;
		checks = 0;
		tests_run = 0;
		test_sequential();
		test_base_decode();
		test_m_ext();
		test_imm_fields();
		test_backpressure();
		test_redirect();
		errors += dut_i.instr_fetch_i.fetch_chk.fails;
		errors += dut_i.decode_stage_i.dec_chk.fails;
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/frontend_assert.sv
`default_nettype none

module frontend_assert (
	input wire logic        clk,
	input wire logic        rst,
	input wire logic        cyc,
	input wire logic        stb,
	input wire logic [31:0] adr,
	input wire logic        ack,
	input wire logic        vld,
	input wire logic        rdy,
	input wire logic        flush,
	input wire logic [84:0] out_word
);

	int fails = 0;

	cyc_ends_after_ack: assert property (@(posedge clk) disable iff (rst)
		cyc && stb && ack |=> !cyc && !stb)
		else begin
			$error("wb_cyc or wb_stb still high after wb_ack");
			fails++;
		end

	adr_stable: assert property (@(posedge clk) disable iff (rst)
		cyc && stb && !ack |=> $stable(adr))
		else begin
			$error("wb_adr changed while the bus cycle waits");
			fails++;
		end

	// a flush may drop the held word.
	dec_hold: assert property (@(posedge clk) disable iff (rst)
		vld && !rdy && !flush |=> vld && $stable(out_word))
		else begin
			$error("dec outputs changed while stalled");
			fails++;
		end

	no_valid_in_reset: assert property (@(posedge clk) $past(rst) |-> !vld)
		else begin
			$error("dec_valid high during reset");
			fails++;
		end

endmodule

bind instr_fetch frontend_assert fetch_chk (
	.clk     (clk),
	.rst     (rst),
	.cyc     (wb_cyc),
	.stb     (wb_stb),
	.adr     (wb_adr),
	.ack     (wb_ack),
	.vld     (1'b0),
	.rdy     (1'b1),
	.flush   (1'b0),
	.out_word(85'd0)
);

bind decode_stage frontend_assert dec_chk (
	.clk     (clk),
	.rst     (rst),
	.cyc     (1'b0),
	.stb     (1'b0),
	.adr     (32'd0),
	.ack     (1'b0),
	.vld     (dec_valid),
	.rdy     (dec_ready),
	.flush   (redirect),
	.out_word({dec_op, dec_rd, dec_rs1, dec_rs2, dec_imm, dec_pc})
);

`default_nettype wire

//--- logic/frontend_top.sv
`default_nettype none

module frontend_top #(
	parameter bit               riscv_m_core = 1'b1,
	parameter wb_pkg::wb_addr_t reset_pc = '0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        redirect,
	input  wb_pkg::wb_addr_t            redirect_pc,
	output logic                        wb_cyc,
	output logic                        wb_stb,
	output wb_pkg::wb_addr_t            wb_adr,
	input  wb_pkg::wb_data_t            wb_rdata,
	input  logic                        wb_ack,
	output logic                        dec_valid,
	input  logic                        dec_ready,
	output riscv_isa_pkg::decoded_instr dec_op,
	output riscv_isa_pkg::reg_idx_t     dec_rd,
	output riscv_isa_pkg::reg_idx_t     dec_rs1,
	output riscv_isa_pkg::reg_idx_t     dec_rs2,
	output wb_pkg::wb_data_t            dec_imm,
	output wb_pkg::wb_data_t            dec_pc
);

	fetch_if fetch_bus ();

	instr_fetch #(
		.reset_pc(reset_pc)
	) instr_fetch_i (
		.clk        (clk),
		.rst        (rst),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_adr     (wb_adr),
		.wb_rdata   (wb_rdata),
		.wb_ack     (wb_ack),
		.fetch      (fetch_bus.source)
	);

	decode_stage #(
		.riscv_m_core(riscv_m_core)
	) decode_stage_i (
		.clk      (clk),
		.rst      (rst),
		.redirect (redirect),
		.fetch    (fetch_bus.sink),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_op   (dec_op),
		.dec_rd   (dec_rd),
		.dec_rs1  (dec_rs1),
		.dec_rs2  (dec_rs2),
		.dec_imm  (dec_imm),
		.dec_pc   (dec_pc)
	);

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage #(
	parameter bit riscv_m_core = 1'b1
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        redirect,
	fetch_if.sink                       fetch,
	output logic                        dec_valid,
	input  logic                        dec_ready,
	output riscv_isa_pkg::decoded_instr dec_op,
	output riscv_isa_pkg::reg_idx_t     dec_rd,
	output riscv_isa_pkg::reg_idx_t     dec_rs1,
	output riscv_isa_pkg::reg_idx_t     dec_rs2,
	output wb_pkg::wb_data_t            dec_imm,
	output wb_pkg::wb_data_t            dec_pc
);

	import riscv_isa_pkg::*;
	import wb_pkg::*;

	decoded_instr op;
	wb_data_t     imm;
	logic         accept;

	decoder #(
		.riscv_m_core(riscv_m_core)
	) decoder_i (
		.instr(fetch.instr),
		.op   (op)
	);

	imm_gen imm_gen_i (
		.instr(fetch.instr),
		.imm  (imm)
	);

	assign fetch.ready = !dec_valid || dec_ready; // empty, or draining this edge.
	assign accept = fetch.valid && fetch.ready && !redirect;

	always_ff @(posedge clk) begin
		if (rst || redirect)
			dec_valid <= 1'b0;
		else if (accept)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_op <= op;
			dec_rd <= fetch.instr.r.rd;
			dec_rs1 <= fetch.instr.r.rs1;
			dec_rs2 <= fetch.instr.r.rs2;
			dec_imm <= imm;
			dec_pc <= fetch.pc;
		end
	end

endmodule

`default_nettype wire

//--- logic/instr_fetch.sv
`default_nettype none

module instr_fetch #(
	parameter wb_pkg::wb_addr_t reset_pc = '0
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             redirect,
	input  wb_pkg::wb_addr_t redirect_pc,
	output logic             wb_cyc,
	output logic             wb_stb,
	output wb_pkg::wb_addr_t wb_adr,
	input  wb_pkg::wb_data_t wb_rdata,
	input  logic             wb_ack,
	fetch_if.source          fetch
);

	import wb_pkg::*;

	typedef enum logic [1:0] {st_idle, st_bus, st_hold} state_t;

	state_t   state;
	wb_addr_t pc;
	wb_addr_t redirect_target;
	logic     redirect_pending; // bus cycle in flight belongs to the old path.
	wb_data_t word;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			pc <= reset_pc;
			redirect_pending <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					state <= st_bus;
					if (redirect)
						pc <= redirect_pc;
				end
				st_bus: begin
					if (wb_ack) begin
						redirect_pending <= 1'b0;
						if (redirect) begin
							pc <= redirect_pc;
							state <= st_idle;
						end else if (redirect_pending) begin
							pc <= redirect_target;
							state <= st_idle; // drop the stale word.
						end else begin
							state <= st_hold;
						end
					end else if (redirect) begin
						redirect_pending <= 1'b1;
					end
				end
				st_hold: begin
					if (redirect) begin
						pc <= redirect_pc;
						state <= st_bus;
					end else if (fetch.ready) begin
						pc <= pc + 32'd4;
						state <= st_bus;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// latest redirect wins while a bus cycle drains.
	always_ff @(posedge clk) begin
		if (redirect)
			redirect_target <= redirect_pc;
	end

	always_ff @(posedge clk) begin
		if (state == st_bus && wb_ack)
			word <= wb_rdata;
	end

	assign wb_cyc = (state == st_bus);
	assign wb_stb = (state == st_bus);
	assign wb_adr = pc;

	assign fetch.valid = (state == st_hold);
	assign fetch.instr = word;
	assign fetch.pc = pc;

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`default_nettype none

module imm_gen (
	input  riscv_isa_pkg::instr_word_t instr,
	output wb_pkg::wb_data_t           imm
);

	import riscv_isa_pkg::*;
	import wb_pkg::*;

	wb_data_t imm_i;
	wb_data_t imm_s;
	wb_data_t imm_b;
	wb_data_t imm_u;
	wb_data_t imm_j;

	assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
	assign imm_s = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
	assign imm_b = {{19{instr.sb.imm_hi[6]}}, instr.sb.imm_hi[6], instr.sb.imm_lo[0],
		instr.sb.imm_hi[5:0], instr.sb.imm_lo[4:1], 1'b0};
	assign imm_u = {instr.uj.imm_31_12, 12'b0};
	// j immediate sits as imm[20|10:1|11|19:12] in the top field.
	assign imm_j = {{11{instr.uj.imm_31_12[19]}}, instr.uj.imm_31_12[19],
		instr.uj.imm_31_12[7:0], instr.uj.imm_31_12[8], instr.uj.imm_31_12[18:9], 1'b0};

	always_comb begin
		case (instr.r.opcode)
			OPCODE_COMPIMM, OPCODE_LOAD, OPCODE_JALR: imm = imm_i;
			OPCODE_STORE:                             imm = imm_s;
			OPCODE_BRANCH:                            imm = imm_b;
			OPCODE_LUI, OPCODE_AUIPC:                 imm = imm_u;
			OPCODE_JAL:                               imm = imm_j;
			default:                                  imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/decoder.sv
`default_nettype none

module decoder #(
	parameter bit riscv_m_core = 1'b1
) (
	input  riscv_isa_pkg::instr_word_t  instr,
	output riscv_isa_pkg::decoded_instr op
);

	import riscv_isa_pkg::*;

	logic [6:0]   funct7;
	logic [2:0]   funct3;
	logic         is_muldiv;
	decoded_instr comp_op;
	decoded_instr compimm_op;
	decoded_instr store_op;
	decoded_instr load_op;
	decoded_instr branch_op;
	decoded_instr muldiv_op;

	assign funct7 = instr.r.funct7;
	assign funct3 = instr.r.funct3;
	assign is_muldiv = riscv_m_core && funct7[0];

	// register-register ops, funct7[5] splits add/sub and the right shifts.
	always_comb begin
		case (funct3)
			3'b000:  comp_op = funct7[5] ? INSTR_SUB : INSTR_ADD;
			3'b001:  comp_op = INSTR_SLL;
			3'b010:  comp_op = INSTR_SLT;
			3'b011:  comp_op = INSTR_SLTU;
			3'b100:  comp_op = INSTR_XOR;
			3'b101:  comp_op = funct7[5] ? INSTR_SRA : INSTR_SRL;
			3'b110:  comp_op = INSTR_OR;
			default: comp_op = INSTR_AND;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  compimm_op = INSTR_ADDI;
			3'b001:  compimm_op = INSTR_SLLI;
			3'b010:  compimm_op = INSTR_SLTI;
			3'b011:  compimm_op = INSTR_SLTIU;
			3'b100:  compimm_op = INSTR_XORI;
			3'b101:  compimm_op = funct7[5] ? INSTR_SRAI : INSTR_SRLI;
			3'b110:  compimm_op = INSTR_ORI;
			default: compimm_op = INSTR_ANDI;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  store_op = INSTR_SB;
			3'b001:  store_op = INSTR_SH;
			default: store_op = INSTR_SW;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  load_op = INSTR_LB;
			3'b001:  load_op = INSTR_LH;
			3'b100:  load_op = INSTR_LBU;
			3'b101:  load_op = INSTR_LHU;
			default: load_op = INSTR_LW;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b001:  branch_op = INSTR_BNE;
			3'b100:  branch_op = INSTR_BLT;
			3'b101:  branch_op = INSTR_BGE;
			3'b110:  branch_op = INSTR_BLTU;
			3'b111:  branch_op = INSTR_BGEU;
			default: branch_op = INSTR_BEQ; // 010 and 011 fall back to beq.
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  muldiv_op = INSTR_MUL;
			3'b001:  muldiv_op = INSTR_MULH;
			3'b010:  muldiv_op = INSTR_MULHSU;
			3'b011:  muldiv_op = INSTR_MULHU;
			3'b100:  muldiv_op = INSTR_DIV;
			3'b101:  muldiv_op = INSTR_DIVU;
			3'b110:  muldiv_op = INSTR_REM;
			default: muldiv_op = INSTR_REMU;
		endcase
	end

	always_comb begin
		case (instr.r.opcode)
			OPCODE_COMP:    op = is_muldiv ? muldiv_op : comp_op;
			OPCODE_COMPIMM: op = compimm_op;
			OPCODE_STORE:   op = store_op;
			OPCODE_LOAD:    op = load_op;
			OPCODE_BRANCH:  op = branch_op;
			OPCODE_JALR:    op = INSTR_JALR;
			OPCODE_JAL:     op = INSTR_JAL;
			OPCODE_AUIPC:   op = INSTR_AUIPC;
			OPCODE_LUI:     op = INSTR_LUI;
			default:        op = INSTR_ILLEGAL;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/fetch_if.sv
`default_nettype none

interface fetch_if;

	logic                      valid;
	logic                      ready;
	riscv_isa_pkg::instr_word_t instr;
	wb_pkg::wb_addr_t          pc;

	modport source (
		output valid, instr, pc,
		input  ready
	);

	modport sink (
		input  valid, instr, pc,
		output ready
	);

endinterface

`default_nettype wire

//--- logic/wb_pkg.sv
`default_nettype none

// instruction bus is byte addressed, word wide.
package wb_pkg;

	localparam int WB_ADDR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = 32;

	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

`default_nettype wire

//--- logic/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

	localparam int WORD_WIDTH = 32;

	typedef logic [4:0] reg_idx_t;

	typedef enum logic [6:0] {
		OPCODE_COMP    = 7'b0110011,
		OPCODE_COMPIMM = 7'b0010011,
		OPCODE_LOAD    = 7'b0000011,
		OPCODE_STORE   = 7'b0100011,
		OPCODE_BRANCH  = 7'b1100011,
		OPCODE_JAL     = 7'b1101111,
		OPCODE_JALR    = 7'b1100111,
		OPCODE_AUIPC   = 7'b0010111,
		OPCODE_LUI     = 7'b0110111
	} opcode_t;

	// base integer set first, then the M operations.
	typedef enum logic [5:0] {
		INSTR_ADD, INSTR_SUB, INSTR_SLL, INSTR_SLT, INSTR_SLTU,
		INSTR_XOR, INSTR_SRL, INSTR_SRA, INSTR_OR, INSTR_AND,
		INSTR_ADDI, INSTR_SLTI, INSTR_SLTIU, INSTR_XORI, INSTR_ORI,
		INSTR_ANDI, INSTR_SLLI, INSTR_SRLI, INSTR_SRAI,
		INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
		INSTR_SB, INSTR_SH, INSTR_SW,
		INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU,
		INSTR_JAL, INSTR_JALR, INSTR_AUIPC, INSTR_LUI,
		INSTR_MUL, INSTR_MULH, INSTR_MULHSU, INSTR_MULHU,
		INSTR_DIV, INSTR_DIVU, INSTR_REM, INSTR_REMU,
		INSTR_ILLEGAL
	} decoded_instr;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} r_format_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		opcode_t     opcode;
	} i_format_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5] for stores, scrambled for branches.
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} sb_format_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_idx_t    rd;
		opcode_t     opcode;
	} uj_format_t;

	typedef union packed {
		r_format_t  r;
		i_format_t  i;
		sb_format_t sb;
		uj_format_t uj;
	} instr_word_t;

endpackage

`default_nettype wire
